// File: src/rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;

  //////////////////////////////////////////////////
  // opcodes and alu operations.
  //////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  // funct7[5] on top of funct3.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  //////////////////////////////////////////////////
  // stage packets.
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] sdata;
    logic [XLEN-1:0] imm;
    logic [4:0]      rd;
    alu_op_e         alu_op;
    logic [2:0]      funct3;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_load;
    logic            is_store;
    logic            writes_rd;
  } dec_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
    logic            req;
  } mem_req_t;

  typedef struct packed {
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic            rd_we;
  } commit_t;

endpackage

// File: src/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            mem_gnt_i,
  input  mem_rsp_t        mem_rsp_i,
  input  logic            dec_ready_i,
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic            halt_i,
  output mem_req_t        mem_req_o,
  output logic            fetch_valid_o,
  output logic [31:0]     fetch_inst_o,
  output logic [XLEN-1:0] fetch_pc_o
);
  logic            run_q;
  logic            inflight_q;
  logic            buf_valid_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] req_pc_q;
  logic [31:0]     buf_inst_q;
  logic [XLEN-1:0] buf_pc_q;
  logic            rsp_ok;

  // one word in flight, nothing new while the skid register is full.
  assign mem_req_o.req   = run_q & !halt_i & !redirect_i & !inflight_q & !buf_valid_q;
  assign mem_req_o.addr  = {2'b00, pc_q[XLEN-1:2]};
  assign mem_req_o.wdata = '0;
  assign mem_req_o.we    = 1'b0;

  // a response arriving with a redirect is wrong path.
  assign rsp_ok = mem_rsp_i.rvalid & inflight_q & !redirect_i;

  assign fetch_valid_o = buf_valid_q | rsp_ok;
  assign fetch_inst_o  = buf_valid_q ? buf_inst_q : mem_rsp_i.rdata;
  assign fetch_pc_o    = buf_valid_q ? buf_pc_q : req_pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q       <= 1'b0;
      inflight_q  <= 1'b0;
      buf_valid_q <= 1'b0;
      pc_q        <= RESET_PC;
    end else begin
      run_q      <= 1'b1;
      inflight_q <= mem_gnt_i;
      if (redirect_i) begin
        pc_q        <= redirect_pc_i;
        buf_valid_q <= 1'b0;
      end else begin
        if (mem_gnt_i) begin
          pc_q <= pc_q + 4;
        end
        if (rsp_ok && !dec_ready_i) begin
          buf_valid_q <= 1'b1;
        end else if (buf_valid_q && dec_ready_i) begin
          buf_valid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_gnt_i) begin
      req_pc_q <= pc_q;
    end
    if (rsp_ok && !dec_ready_i) begin
      buf_inst_q <= mem_rsp_i.rdata;
      buf_pc_q   <= req_pc_q;
    end
  end

endmodule

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_valid_i,
  input  logic [31:0]     fetch_inst_i,
  input  logic [XLEN-1:0] fetch_pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  logic [31:0]     busy_i,
  input  logic            ex_ready_i,
  input  logic            flush_i,
  output logic            dec_ready_o,
  output logic [4:0]      rs1_addr_o,
  output logic [4:0]      rs2_addr_o,
  output logic            set_busy_o,
  output logic [4:0]      set_busy_rd_o,
  output logic            dec_valid_o,
  output dec_pkt_t        dec_pkt_o,
  output logic            illegal_o
);
  logic            valid_q;
  logic            illegal_q;
  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;
  opcode_e         opcode;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            bad_op;
  logic            stall;
  logic            issue;

  //////////////////////////////////////////////////
  // fields and immediates.
  //////////////////////////////////////////////////

  assign opcode     = opcode_e'(inst_q[6:0]);
  assign rd         = inst_q[11:7];
  assign funct3     = inst_q[14:12];
  assign rs1_addr_o = inst_q[19:15];
  assign rs2_addr_o = inst_q[24:20];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  //////////////////////////////////////////////////
  // handshakes and busy-table stall.
  //////////////////////////////////////////////////

  // lui, auipc and jal read no register.
  assign stall = !(opcode inside {OP_LUI, OP_AUIPC, OP_JAL}) &
                 (busy_i[rs1_addr_o] | busy_i[rs2_addr_o]);

  assign dec_valid_o = valid_q & !stall & !bad_op & !illegal_q;
  assign issue       = dec_valid_o & ex_ready_i;
  assign dec_ready_o = !illegal_q & !flush_i & (!valid_q | issue);

  assign set_busy_o    = issue & dec_pkt_o.writes_rd;
  assign set_busy_rd_o = rd;
  assign illegal_o     = illegal_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= illegal_q | (valid_q & bad_op & !flush_i);
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (fetch_valid_i && dec_ready_o) begin
        valid_q <= 1'b1;
      end else if (issue) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i && dec_ready_o) begin
      inst_q <= fetch_inst_i;
      pc_q   <= fetch_pc_i;
    end
  end

  //////////////////////////////////////////////////
  // operand selection.
  //////////////////////////////////////////////////

  always_comb begin
    bad_op           = 1'b0;
    dec_pkt_o        = '0;
    dec_pkt_o.pc     = pc_q;
    dec_pkt_o.rd     = rd;
    dec_pkt_o.funct3 = funct3;
    dec_pkt_o.alu_op = ALU_ADD;
    dec_pkt_o.op1    = rs1_data_i;
    dec_pkt_o.op2    = imm_i;
    dec_pkt_o.imm    = imm_i;
    dec_pkt_o.sdata  = rs2_data_i;
    case (opcode)
      OP_LUI: begin
        dec_pkt_o.op1       = '0;
        dec_pkt_o.op2       = imm_u;
        dec_pkt_o.writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        dec_pkt_o.op1       = pc_q;
        dec_pkt_o.op2       = imm_u;
        dec_pkt_o.writes_rd = 1'b1;
      end
      // jumps link through the alu as pc plus 4.
      OP_JAL: begin
        dec_pkt_o.op1       = pc_q;
        dec_pkt_o.op2       = 4;
        dec_pkt_o.imm       = imm_j;
        dec_pkt_o.is_jal    = 1'b1;
        dec_pkt_o.writes_rd = 1'b1;
      end
      OP_JALR: begin
        dec_pkt_o.op1       = pc_q;
        dec_pkt_o.op2       = 4;
        dec_pkt_o.sdata     = rs1_data_i;  // jump base.
        dec_pkt_o.is_jalr   = 1'b1;
        dec_pkt_o.writes_rd = 1'b1;
      end
      OP_BRANCH: begin
        dec_pkt_o.op2       = rs2_data_i;
        dec_pkt_o.imm       = imm_b;
        dec_pkt_o.is_branch = 1'b1;
      end
      OP_IMM: begin
        dec_pkt_o.alu_op    = alu_op_e'({(funct3 == 3'b101) & inst_q[30], funct3});
        dec_pkt_o.writes_rd = 1'b1;
      end
      OP_LOAD: begin
        dec_pkt_o.is_load   = 1'b1;
        dec_pkt_o.writes_rd = 1'b1;
      end
      OP_STORE: begin
        dec_pkt_o.op2      = imm_s;
        dec_pkt_o.imm      = imm_s;
        dec_pkt_o.is_store = 1'b1;
      end
      OP_REG: begin
        dec_pkt_o.op2       = rs2_data_i;
        dec_pkt_o.alu_op    = alu_op_e'({inst_q[30], funct3});
        dec_pkt_o.writes_rd = 1'b1;
      end
      default: bad_op = 1'b1;
    endcase
    dec_pkt_o.writes_rd = dec_pkt_o.writes_rd & (rd != 5'd0);
  end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1_addr_i,
  input  logic [4:0]      rs2_addr_i,
  input  logic            we_i,
  input  logic [4:0]      waddr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            set_busy_i,
  input  logic [4:0]      set_busy_rd_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  output logic [31:0]     busy_o
);
  logic [XLEN-1:0] regs [32];
  logic [31:0]     busy_q;

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];
  assign busy_o     = busy_q;

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a new issue wins over a writeback of the same register.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      for (int i = 0; i < 32; i++) begin
        if (set_busy_i && set_busy_rd_i == 5'(i)) begin
          busy_q[i] <= 1'b1;
        end else if (we_i && waddr_i == 5'(i)) begin
          busy_q[i] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: src/rv_exec.sv
`timescale 1ns/1ps

module rv_exec
  import rv_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            dec_valid_i,
  input  dec_pkt_t        dec_pkt_i,
  input  logic            mem_gnt_i,
  input  mem_rsp_t        mem_rsp_i,
  output logic            ex_ready_o,
  output mem_req_t        mem_req_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o,
  output logic            rf_we_o,
  output logic [4:0]      rf_waddr_o,
  output logic [XLEN-1:0] rf_wdata_o,
  output logic            commit_valid_o,
  output commit_t         commit_o
);
  typedef enum logic [1:0] {IDLE, MEM_REQ, MEM_WAIT} ex_state_e;

  ex_state_e       state;
  logic            ex_valid_q;
  dec_pkt_t        pkt_q;
  logic [XLEN-1:0] load_q;
  logic [XLEN-1:0] alu_res;
  logic            taken;
  logic            accept;
  logic            is_mem;

  //////////////////////////////////////////////////
  // alu and branch compare.
  //////////////////////////////////////////////////

  always_comb begin
    case (pkt_q.alu_op)
      ALU_SUB:  alu_res = pkt_q.op1 - pkt_q.op2;
      ALU_SLL:  alu_res = pkt_q.op1 << pkt_q.op2[4:0];
      ALU_SLT:  alu_res = XLEN'($signed(pkt_q.op1) < $signed(pkt_q.op2));
      ALU_SLTU: alu_res = XLEN'(pkt_q.op1 < pkt_q.op2);
      ALU_XOR:  alu_res = pkt_q.op1 ^ pkt_q.op2;
      ALU_SRL:  alu_res = pkt_q.op1 >> pkt_q.op2[4:0];
      ALU_SRA:  alu_res = $signed(pkt_q.op1) >>> pkt_q.op2[4:0];
      ALU_OR:   alu_res = pkt_q.op1 | pkt_q.op2;
      ALU_AND:  alu_res = pkt_q.op1 & pkt_q.op2;
      default:  alu_res = pkt_q.op1 + pkt_q.op2;
    endcase
  end

  always_comb begin
    case (pkt_q.funct3)
      3'b000:  taken = pkt_q.op1 == pkt_q.op2;
      3'b001:  taken = pkt_q.op1 != pkt_q.op2;
      3'b100:  taken = $signed(pkt_q.op1) < $signed(pkt_q.op2);
      3'b101:  taken = $signed(pkt_q.op1) >= $signed(pkt_q.op2);
      3'b110:  taken = pkt_q.op1 < pkt_q.op2;
      3'b111:  taken = pkt_q.op1 >= pkt_q.op2;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_o = ex_valid_q & (pkt_q.is_jal | pkt_q.is_jalr | (pkt_q.is_branch & taken));
  assign redirect_pc_o = pkt_q.is_jalr ? ((pkt_q.sdata + pkt_q.imm) & ~XLEN'(1))
                                       : (pkt_q.pc + pkt_q.imm);

  //////////////////////////////////////////////////
  // issue, memory access and commit.
  //////////////////////////////////////////////////

  // nothing enters behind a redirecting instruction.
  assign ex_ready_o = (state == IDLE) & !redirect_o;
  assign accept     = dec_valid_i & ex_ready_o;
  assign is_mem     = dec_pkt_i.is_load | dec_pkt_i.is_store;

  assign mem_req_o.req   = (state == MEM_REQ);
  assign mem_req_o.addr  = {2'b00, alu_res[XLEN-1:2]};
  assign mem_req_o.wdata = pkt_q.sdata;
  assign mem_req_o.we    = pkt_q.is_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      ex_valid_q <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          ex_valid_q <= accept & !is_mem;
          if (accept && is_mem) begin
            state <= MEM_REQ;
          end
        end
        MEM_REQ: begin
          if (mem_gnt_i) begin
            state <= MEM_WAIT;
          end
        end
        MEM_WAIT: begin
          if (mem_rsp_i.rvalid) begin
            state      <= IDLE;
            ex_valid_q <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= dec_pkt_i;
    end
    if (state == MEM_WAIT && mem_rsp_i.rvalid) begin
      load_q <= mem_rsp_i.rdata;
    end
  end

  assign commit_valid_o = ex_valid_q;
  assign commit_o.pc    = pkt_q.pc;
  assign commit_o.rd    = pkt_q.rd;
  assign commit_o.data  = pkt_q.is_load ? load_q : alu_res;
  assign commit_o.rd_we = pkt_q.writes_rd;

  assign rf_we_o    = ex_valid_q & pkt_q.writes_rd;
  assign rf_waddr_o = pkt_q.rd;
  assign rf_wdata_o = commit_o.data;

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  mem_req_t ex_req_i,
  input  mem_req_t if_req_i,
  input  mem_rsp_t mem_rsp_i,
  output logic     ex_gnt_o,
  output logic     if_gnt_o,
  output mem_rsp_t ex_rsp_o,
  output mem_rsp_t if_rsp_o,
  output mem_req_t mem_req_o
);
  logic rsp_to_ex_q;

  // execute always wins.
  assign ex_gnt_o = ex_req_i.req;
  assign if_gnt_o = if_req_i.req & !ex_req_i.req;

  always_comb begin
    mem_req_o = '0;
    if (ex_gnt_o) begin
      mem_req_o = ex_req_i;
    end else if (if_gnt_o) begin
      mem_req_o = if_req_i;
    end
  end

  // owner of the response due next cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_to_ex_q <= 1'b0;
    end else begin
      rsp_to_ex_q <= ex_gnt_o;
    end
  end

  assign ex_rsp_o.rvalid = mem_rsp_i.rvalid & rsp_to_ex_q;
  assign ex_rsp_o.rdata  = mem_rsp_i.rdata;
  assign if_rsp_o.rvalid = mem_rsp_i.rvalid & !rsp_to_ex_q;
  assign if_rsp_o.rdata  = mem_rsp_i.rdata;

endmodule

// File: src/unified_mem.sv
`timescale 1ns/1ps

module unified_mem
  import rv_pkg::*;
#(
  parameter int DEPTH = 256
) (
  input  logic                     clk,
  input  mem_req_t                 mem_req_i,
  input  logic                     load_we_i,
  input  logic [$clog2(DEPTH)-1:0] load_addr_i,
  input  logic [XLEN-1:0]          load_data_i,
  output mem_rsp_t                 mem_rsp_o
);
  localparam int AW = $clog2(DEPTH);

  logic [XLEN-1:0] mem [DEPTH];

  // program load takes the write port first.
  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem[load_addr_i] <= load_data_i;
    end else if (mem_req_i.req && mem_req_i.we) begin
      mem[mem_req_i.addr[AW-1:0]] <= mem_req_i.wdata;
    end
    mem_rsp_o.rvalid <= mem_req_i.req;
    mem_rsp_o.rdata  <= mem[mem_req_i.addr[AW-1:0]];
  end

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top
  import rv_pkg::*;
#(
  parameter int              DEPTH    = 256,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     load_we_i,
  input  logic [$clog2(DEPTH)-1:0] load_addr_i,
  input  logic [XLEN-1:0]          load_data_i,
  output logic                     commit_valid_o,
  output commit_t                  commit_o,
  output logic                     illegal_o
);
  mem_req_t        if_req;
  mem_req_t        ex_req;
  mem_req_t        mem_req;
  mem_rsp_t        if_rsp;
  mem_rsp_t        ex_rsp;
  mem_rsp_t        mem_rsp;
  logic            if_gnt;
  logic            ex_gnt;
  logic            fetch_valid;
  logic [31:0]     fetch_inst;
  logic [XLEN-1:0] fetch_pc;
  logic            dec_ready;
  logic            dec_valid;
  dec_pkt_t        dec_pkt;
  logic [4:0]      rs1_addr;
  logic [4:0]      rs2_addr;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [31:0]     busy;
  logic            set_busy;
  logic [4:0]      set_busy_rd;
  logic            ex_ready;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic            rf_we;
  logic [4:0]      rf_waddr;
  logic [XLEN-1:0] rf_wdata;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk, .rst,
    .mem_gnt_i(if_gnt), .mem_rsp_i(if_rsp), .dec_ready_i(dec_ready),
    .redirect_i(redirect), .redirect_pc_i(redirect_pc), .halt_i(illegal_o),
    .mem_req_o(if_req), .fetch_valid_o(fetch_valid),
    .fetch_inst_o(fetch_inst), .fetch_pc_o(fetch_pc)
  );

  rv_decode u_decode (
    .clk, .rst,
    .fetch_valid_i(fetch_valid), .fetch_inst_i(fetch_inst), .fetch_pc_i(fetch_pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .busy_i(busy),
    .ex_ready_i(ex_ready), .flush_i(redirect),
    .dec_ready_o(dec_ready), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .set_busy_o(set_busy), .set_busy_rd_o(set_busy_rd),
    .dec_valid_o(dec_valid), .dec_pkt_o(dec_pkt), .illegal_o(illegal_o)
  );

  rv_regfile u_regfile (
    .clk, .rst,
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .set_busy_i(set_busy), .set_busy_rd_i(set_busy_rd),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .busy_o(busy)
  );

  rv_exec u_exec (
    .clk, .rst,
    .dec_valid_i(dec_valid), .dec_pkt_i(dec_pkt),
    .mem_gnt_i(ex_gnt), .mem_rsp_i(ex_rsp),
    .ex_ready_o(ex_ready), .mem_req_o(ex_req),
    .redirect_o(redirect), .redirect_pc_o(redirect_pc),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .commit_valid_o(commit_valid_o), .commit_o(commit_o)
  );

  mem_arbiter u_arbiter (
    .clk, .rst,
    .ex_req_i(ex_req), .if_req_i(if_req), .mem_rsp_i(mem_rsp),
    .ex_gnt_o(ex_gnt), .if_gnt_o(if_gnt),
    .ex_rsp_o(ex_rsp), .if_rsp_o(if_rsp), .mem_req_o(mem_req)
  );

  unified_mem #(
    .DEPTH(DEPTH)
  ) u_mem (
    .clk,
    .mem_req_i(mem_req), .load_we_i(load_we_i),
    .load_addr_i(load_addr_i), .load_data_i(load_data_i),
    .mem_rsp_o(mem_rsp)
  );

endmodule

// File: verif/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert
  import rv_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        ex_gnt_i,
  input logic        if_gnt_i,
  input logic        ex_rvalid_i,
  input logic        if_rvalid_i,
  input logic        dec_valid_i,
  input opcode_e     opcode_i,
  input logic [4:0]  rs1_addr_i,
  input logic [4:0]  rs2_addr_i,
  input logic        ex_ready_i,
  input logic [4:0]  ex_rd_i,
  input logic        ex_rd_we_i,
  input logic        commit_valid_i
);
  logic ex_pending;
  logic reads_rs1;
  logic reads_rs2;

  // execute still owes a writeback while busy or committing.
  assign ex_pending = ex_rd_we_i & (!ex_ready_i | commit_valid_i);
  assign reads_rs1  = !(opcode_i inside {OP_LUI, OP_AUIPC, OP_JAL});
  assign reads_rs2  = opcode_i inside {OP_BRANCH, OP_STORE, OP_REG};

  // a grant is answered next cycle and only to its own requester.
  a_ex_rsp: assert property (@(posedge clk) disable iff (rst)
    ex_gnt_i |=> ex_rvalid_i && !if_rvalid_i)
    else $error("execute grant not answered alone on the next cycle");

  a_if_rsp: assert property (@(posedge clk) disable iff (rst)
    if_gnt_i |=> if_rvalid_i && !ex_rvalid_i)
    else $error("fetch grant not answered alone on the next cycle");

  a_no_hazard_issue: assert property (@(posedge clk) disable iff (rst)
    dec_valid_i && ex_pending
      |-> !(reads_rs1 && rs1_addr_i == ex_rd_i) && !(reads_rs2 && rs2_addr_i == ex_rd_i))
    else $error("dec_valid high while a source register waits on execute");

  a_quiet_in_reset: assert property (@(posedge clk)
    rst |=> !commit_valid_i)
    else $error("commit_valid_o high during reset");

endmodule

bind rv_core_top rv_core_assert u_assert (
  .clk(clk), .rst(rst),
  .ex_gnt_i(ex_gnt), .if_gnt_i(if_gnt),
  .ex_rvalid_i(ex_rsp.rvalid), .if_rvalid_i(if_rsp.rvalid),
  .dec_valid_i(dec_valid), .opcode_i(u_decode.opcode),
  .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
  .ex_ready_i(ex_ready), .ex_rd_i(commit_o.rd), .ex_rd_we_i(commit_o.rd_we),
  .commit_valid_i(commit_valid_o)
);

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();
  localparam int DEPTH     = 256;
  localparam int PAT_WORDS = 512;

  logic        clk;
  logic        rst;
  logic        load_we;
  logic [7:0]  load_addr;
  logic [31:0] load_data;
  logic        commit_valid;
  commit_t     commit;
  logic        illegal;

  logic [31:0] pat [PAT_WORDS];
  logic [31:0] prog_addr [$];
  logic [31:0] prog_word [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_rd [$];
  logic [31:0] exp_data [$];
  logic        exp_illegal;
  logic        checking;
  int          seen;
  int          cycles;
  int          limit;

  rv_core_top #(
    .DEPTH(DEPTH),
    .RESET_PC(32'h0)
  ) DUT (
    .clk, .rst,
    .load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
    .commit_valid_o(commit_valid), .commit_o(commit), .illegal_o(illegal)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // checking helpers.
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // rd 0 in the trace means the instruction writes no register.
  task automatic check_commit(input int idx);
    check_value("commit_o.pc", commit.pc, exp_pc[idx]);
    check_value("commit_o.rd_we", 32'(commit.rd_we), 32'(exp_rd[idx] != 0));
    if (exp_rd[idx] != 0) begin
      check_value("commit_o.rd", 32'(commit.rd), exp_rd[idx]);
      check_value("commit_o.data", commit.data, exp_data[idx]);
    end
  endtask

  task automatic read_patterns();
    int i;
    bit found_end;
    $readmemh("verif/rv_core_patterns.hex", pat);
    i = 0;
    found_end = 1'b0;
    while (!found_end && i < PAT_WORDS) begin
      case (pat[i])
        32'h0: begin
          prog_addr.push_back(pat[i+1]);
          prog_word.push_back(pat[i+2]);
        end
        32'h1: begin
          exp_pc.push_back(pat[i+1]);
          exp_rd.push_back(pat[i+2]);
          exp_data.push_back(pat[i+3]);
        end
        32'h2: begin
          exp_illegal = pat[i+1][0];
          found_end   = 1'b1;
        end
        default: begin
          $display("Error: bad record kind %h at word %0d of the patterns file", pat[i], i);
          abort_run();
        end
      endcase
      i += 4;
    end
    if (!found_end) begin
      $display("Error: the patterns file has no end record");
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // commit monitor and watchdog.
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (checking && commit_valid === 1'b1) begin
      if (seen >= exp_pc.size()) begin
        $display("Error: extra commit at pc %h after the last expected one", commit.pc);
        abort_run();
      end else begin
        check_commit(seen);
        seen++;
      end
    end
  end

  always @(posedge clk) begin
    if (checking && seen < exp_pc.size()) begin
      cycles++;
      if (cycles > limit) begin
        $display("Error: timeout after %0d cycles with %0d of %0d commits seen",
                 cycles, seen, exp_pc.size());
        abort_run();
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence.
  //////////////////////////////////////////////////

  initial begin
    int reset_cycles;
    int k;
    rst         = 1'b1;
    load_we     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    checking    = 1'b0;
    seen        = 0;
    cycles      = 0;
    exp_illegal = 1'b0;
    read_patterns();
    limit = 20 * exp_pc.size() + 100;

    // reset spans the program load, and at least 8 cycles.
    reset_cycles = (prog_addr.size() + 1 > 8) ? prog_addr.size() + 1 : 8;
    for (k = 0; k < reset_cycles; k++) begin
      @(posedge clk);
      if (k < prog_addr.size()) begin
        load_we   <= 1'b1;
        load_addr <= prog_addr[k][9:2];
        load_data <= prog_word[k];
      end else begin
        load_we <= 1'b0;
      end
      @(negedge clk);
      check_value("commit_valid_o", 32'(commit_valid), 32'h0);
      check_value("illegal_o", 32'(illegal), 32'h0);
    end

    @(posedge clk);
    rst      <= 1'b0;
    load_we  <= 1'b0;
    checking <= 1'b1;
    @(negedge clk);
    check_value("commit_valid_o", 32'(commit_valid), 32'h0);
    check_value("illegal_o", 32'(illegal), 32'h0);

    while (seen < exp_pc.size()) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_value("illegal_o", 32'(illegal), 32'(exp_illegal));

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: verif/rv_core_patterns.hex
// columns: kind, then three words.
// kind 0 = program (byte address, word, 0); kind 1 = expected commit (pc, rd, data).
// kind 2 = end (expected illegal_o). rd 0 marks a commit without register write.
// program: alu, dependencies, branches and jumps, sw then lw, illegal word.
0 00000000 00500093 0
0 00000004 ffd00113 0
0 00000008 002081b3 0
0 0000000c 40208233 0
0 00000010 00309293 0
0 00000014 40115313 0
0 00000018 001123b3 0
0 0000001c 12345437 0
0 00000020 00001497 0
0 00000024 00208463 0
0 00000028 00209463 0
0 0000002c 06300513 0
0 00000030 008005ef 0
0 00000034 04d00513 0
0 00000038 00c58667 0
0 0000003c 03700513 0
0 00000040 abcde737 0
0 00000044 12370713 0
0 00000048 10e02023 0
0 0000004c 10002783 0
0 00000050 00178833 0
0 00000054 00000000 0
0 00000058 00100513 0
// expected commit trace in program order.
1 00000000 01 00000005
1 00000004 02 fffffffd
1 00000008 03 00000002
1 0000000c 04 00000008
1 00000010 05 00000028
1 00000014 06 fffffffe
1 00000018 07 00000001
1 0000001c 08 12345000
1 00000020 09 00001020
1 00000024 00 00000000
1 00000028 00 00000000
1 00000030 0b 00000034
1 00000038 0c 0000003c
1 00000040 0e abcde000
1 00000044 0e abcde123
1 00000048 00 00000000
1 0000004c 0f abcde123
1 00000050 10 abcde128
2 00000001 0 0

// File: compile.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_exec.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_core_top.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - src/rv_pkg.sv
      - src/rv_fetch.sv
      - src/rv_decode.sv
      - src/rv_regfile.sv
      - src/rv_exec.sv
      - src/mem_arbiter.sv
      - src/unified_mem.sv
      - src/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_assert.sv
      - verif/tb_rv_core.sv
